/* build.f */
+incdir+sim
hw/csa_pkg.sv
hw/csa_regmap_pkg.sv
hw/csa_regs.sv
hw/csa_dispatch.sv
hw/csa_lane.sv
hw/csa_top.sv
sim/csa_tb.sv

/* sim/csa_tb_model.svh */
`ifndef CSA_TB_MODEL_SVH
`define CSA_TB_MODEL_SVH

typedef logic [OUT_WORDS*32-1:0] rec_t; // Word 0 sits in the lowest 32 bits

function automatic digest_t mix_digest(input word_t tag, input seed_t seed,
	input word_t count, input word_t start);
	digest_t st;
	digest_t rot;
	st = {tag, seed[31:0]};
	for (int unsigned j = 0; j < count; j++) begin
		rot = {st[63-ROT_BITS:0], st[63:64-ROT_BITS]};
		st = (rot ^ {16'h0000, seed}) + {32'h0000_0000, start + word_t'(j)};
	end
	return st;
endfunction

// Output record in the order the DUT streams it with the job words before the digest
function automatic rec_t make_record(input word_t tag, input seed_t seed,
	input word_t count, input word_t start);
	digest_t d;
	d = mix_digest(tag, seed, count, start);
	return {d[63:32], d[31:0], start, count, {16'h0000, seed[47:32]}, seed[31:0], tag};
endfunction

`endif

/* sim/csa_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_tb
	import csa_pkg::*, csa_regmap_pkg::*;
;

	`include "csa_tb_model.svh"

	logic axi_mm_clk;
	logic rst_n;
	logic wen_i;
	addr_t waddr_i;
	word_t wdata_i;
	logic ren_i;
	addr_t raddr_i;
	word_t rdata_o;
	logic in_ready_i;
	logic in_ren_o;
	word_t in_rdata_i;
	logic out_full_i;
	logic out_wen_o;
	word_t out_wdata_o;

	integer rand_seed;
	word_t in_q[$]; // Behavioral input FIFO
	rec_t exp_q[$]; // Records still expected at the output
	rec_t last_rec;
	word_t next_tag;
	rec_t cap_rec;
	int cap_cnt;
	logic ren_seen;

	csa_top dut (
		.axi_mm_clk(axi_mm_clk), .rst_n(rst_n),
		.wen_i(wen_i), .waddr_i(waddr_i), .wdata_i(wdata_i),
		.ren_i(ren_i), .raddr_i(raddr_i), .rdata_o(rdata_o),
		.in_ready_i(in_ready_i), .in_ren_o(in_ren_o), .in_rdata_i(in_rdata_i),
		.out_full_i(out_full_i), .out_wen_o(out_wen_o), .out_wdata_o(out_wdata_o)
	);

	always #50 axi_mm_clk = ~axi_mm_clk;

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_digest(input digest_t got, input digest_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_valid(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic step();
		@(posedge axi_mm_clk);
		#1;
	endtask

	task automatic reg_write(input addr_t addr, input word_t data);
		waddr_i = addr;
		wdata_i = data;
		wen_i = 1'b1;
		step();
		wen_i = 1'b0;
	endtask

	task automatic reg_read(input addr_t addr, output word_t data);
		raddr_i = addr;
		ren_i = 1'b1;
		step();
		ren_i = 1'b0;
		data = rdata_o; // Registered one cycle after the strobe
	endtask

	task automatic push_random_job(input word_t count);
		seed_t s;
		word_t r;
		word_t st;
		r = $random(rand_seed);
		s[31:0] = r;
		r = $random(rand_seed);
		s[47:32] = r[15:0];
		st = $random(rand_seed);
		last_rec = make_record(next_tag, s, count, st);
		exp_q.push_back(last_rec);
		for (int k = 0; k < IN_WORDS; k++) begin
			in_q.push_back(last_rec[k*32 +: 32]);
		end
		next_tag = next_tag + word_t'(1);
	endtask

	task automatic wait_drained(input string what);
		int cycles;
		cycles = 0;
		while ((exp_q.size() != 0) && (cycles < 2000)) begin
			step();
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout after 2000 cycles waiting for the %s records, %0d still missing",
				what, exp_q.size());
			abort_run();
		end
	endtask

	task automatic compare_record(input rec_t got);
		int idx;
		rec_t exp;
		word_t tag;
		tag = got[31:0];
		idx = -1;
		foreach (exp_q[i]) begin
			if (exp_q[i][31:0] == tag) begin
				idx = i;
			end
		end
		if (idx < 0) begin
			$display("Output record with tag %h was not expected or arrived twice", tag);
			abort_run();
		end else begin
			exp = exp_q[idx];
			// Word 0 is the tag that found the entry
			for (int k = 1; k < IN_WORDS; k++) begin
				check_word(got[k*32 +: 32], exp[k*32 +: 32],
					$sformatf("word %0d of record %h", k, tag));
			end
			check_digest(got[OUT_WORDS*32-1:IN_WORDS*32], exp[OUT_WORDS*32-1:IN_WORDS*32],
				$sformatf("digest of record %h", tag));
			exp_q.delete(idx);
		end
	endtask

	// The read strobe is sampled before the edge and its word follows one cycle later
	always begin
		@(negedge axi_mm_clk);
		ren_seen = in_ren_o;
		@(posedge axi_mm_clk);
		#1;
		if (ren_seen) begin
			if (in_q.size() == 0) begin
				$display("The DUT read the input FIFO while it was empty");
				abort_run();
			end else begin
				in_rdata_i = in_q.pop_front();
			end
		end
		in_ready_i = (in_q.size() >= IN_WORDS);
	end

	always begin
		@(negedge axi_mm_clk);
		if (rst_n && out_wen_o) begin
			if ((cap_cnt == 0) && out_full_i) begin
				$display("A record started while the output FIFO was full");
				abort_run();
			end
			cap_rec[cap_cnt*32 +: 32] = out_wdata_o;
			cap_cnt++;
			if (cap_cnt == OUT_WORDS) begin
				compare_record(cap_rec);
				cap_cnt = 0;
			end
		end else if (cap_cnt != 0) begin
			$display("An output record was cut short after %0d words", cap_cnt);
			abort_run();
		end
	end

	initial begin
		word_t rd;
		word_t rd_lo;
		logic hit;
		axi_mm_clk = 1'b0;
		rst_n = 1'b0;
		wen_i = 1'b0;
		waddr_i = '0;
		wdata_i = '0;
		ren_i = 1'b0;
		raddr_i = '0;
		in_ready_i = 1'b0;
		in_rdata_i = '0;
		out_full_i = 1'b0;
		rand_seed = 92;
		next_tag = 32'h0000_1000;
		cap_cnt = 0;
		cap_rec = '0;
		hit = 1'b0;

		repeat (16) step();
		rst_n = 1'b1;
		check_word(rdata_o, '0, "read data after reset");
		check_valid(in_ren_o | out_wen_o, 1'b0, "FIFO strobes after reset");

		push_random_job(word_t'(0));
		wait_drained("count 0");
		push_random_job(word_t'(5));
		wait_drained("count 5");

		for (int n = 0; n < 12; n++) begin
			push_random_job(word_t'($unsigned($random(rand_seed)) % 31));
		end
		wait_drained("random");

		for (int n = 0; n < 10; n++) begin
			push_random_job(word_t'($unsigned($random(rand_seed)) % 31));
		end
		repeat (30) step();
		out_full_i = 1'b1; // Lanes fill up behind the blocked output
		repeat (200) step();
		out_full_i = 1'b0;
		wait_drained("backpressure");

		reg_write(ADDR_CHANNEL, word_t'(2));
		reg_read(ADDR_CHANNEL, rd);
		check_word(rd, word_t'(2), "channel after a write of 2");
		reg_read(ADDR_IN_VALID, rd);
		check_valid(rd[0], 1'b0, "input valid after the channel change");
		reg_read(ADDR_OUT_VALID, rd);
		check_valid(rd[0], 1'b0, "output valid after the channel change");
		reg_write(ADDR_CHANNEL, word_t'(7));
		reg_read(ADDR_CHANNEL, rd);
		check_word(rd, word_t'(2), "channel after a write of 7");

		// With all lanes empty the jobs go to consecutive lanes
		for (int t = 0; (t < LANE_NUM) && !hit; t++) begin
			push_random_job(word_t'($unsigned($random(rand_seed)) % 31));
			wait_drained("lane 2 probe");
			reg_read(ADDR_IN_VALID, rd);
			hit = rd[0];
			if (!hit) begin
				reg_read(ADDR_OUT_VALID, rd);
				check_valid(rd[0], 1'b0, "output valid for a job outside lane 2");
			end
		end
		if (!hit) begin
			$display("No job reached lane 2 in %0d tries", LANE_NUM);
			abort_run();
		end
		reg_read(ADDR_OUT_VALID, rd);
		check_valid(rd[0], 1'b1, "output valid after the lane 2 job");
		for (int k = 0; k < IN_WORDS; k++) begin
			reg_read(addr_t'(ADDR_IN_0 + k), rd);
			check_word(rd, last_rec[k*32 +: 32], $sformatf("input snapshot word %0d", k));
			reg_read(addr_t'(ADDR_OUT_0 + k), rd);
			check_word(rd, last_rec[k*32 +: 32], $sformatf("output snapshot word %0d", k));
		end
		reg_read(ADDR_OUT_5, rd_lo);
		reg_read(ADDR_OUT_6, rd);
		check_digest({rd, rd_lo}, last_rec[OUT_WORDS*32-1:IN_WORDS*32], "output snapshot digest");

		reg_read(addr_t'(40), rd);
		check_word(rd, 32'hE000_0028, "read of unmapped address 40");

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/csa_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_top
	import csa_pkg::*, csa_regmap_pkg::*;
(
	input  logic  axi_mm_clk,
	input  logic  rst_n,
	input  logic  wen_i,
	input  addr_t waddr_i,
	input  word_t wdata_i,
	input  logic  ren_i,
	input  addr_t raddr_i,
	output word_t rdata_o,
	input  logic  in_ready_i,
	output logic  in_ren_o,
	input  word_t in_rdata_i,
	input  logic  out_full_i,
	output logic  out_wen_o,
	output word_t out_wdata_o
);

	lane_idx_t channel;
	logic snap_in_we;
	logic snap_out_we;
	word_t snap_tag;
	word_t snap_count;
	word_t snap_start;
	seed_t snap_seed;
	digest_t snap_digest;

	lane_mask_t lane_full;
	lane_mask_t lane_ready;
	lane_mask_t lane_wen;
	lane_mask_t lane_ren;
	word_t job_tag;
	word_t job_count;
	word_t job_start;
	seed_t job_seed;

	word_t lane_tag [LANE_NUM];
	word_t lane_count [LANE_NUM];
	word_t lane_start [LANE_NUM];
	seed_t lane_seed [LANE_NUM];
	digest_t lane_digest [LANE_NUM];
	lane_idx_t sel_idx; // Lane read last whose fields are valid one cycle after the read

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			sel_idx <= '0;
		end else begin
			for (int i = 0; i < LANE_NUM; i++) begin
				if (lane_ren[i]) begin
					sel_idx <= lane_idx_t'(i);
				end
			end
		end
	end

	csa_regs u_regs (
		.axi_mm_clk(axi_mm_clk), .rst_n(rst_n),
		.wen_i(wen_i), .waddr_i(waddr_i), .wdata_i(wdata_i),
		.ren_i(ren_i), .raddr_i(raddr_i), .rdata_o(rdata_o),
		.channel_o(channel),
		.snap_in_we_i(snap_in_we), .snap_out_we_i(snap_out_we),
		.snap_tag_i(snap_tag), .snap_count_i(snap_count), .snap_start_i(snap_start),
		.snap_seed_i(snap_seed), .snap_digest_i(snap_digest)
	);

	csa_dispatch u_dispatch (
		.axi_mm_clk(axi_mm_clk), .rst_n(rst_n), .channel_i(channel),
		.in_ready_i(in_ready_i), .in_ren_o(in_ren_o), .in_rdata_i(in_rdata_i),
		.out_full_i(out_full_i), .out_wen_o(out_wen_o), .out_wdata_o(out_wdata_o),
		.lane_full_i(lane_full), .lane_ready_i(lane_ready),
		.lane_wen_o(lane_wen), .lane_ren_o(lane_ren),
		.job_tag_o(job_tag), .job_count_o(job_count), .job_start_o(job_start),
		.job_seed_o(job_seed),
		.ret_tag_i(lane_tag[sel_idx]), .ret_count_i(lane_count[sel_idx]),
		.ret_start_i(lane_start[sel_idx]), .ret_seed_i(lane_seed[sel_idx]),
		.ret_digest_i(lane_digest[sel_idx]),
		.snap_in_we_o(snap_in_we), .snap_out_we_o(snap_out_we),
		.snap_tag_o(snap_tag), .snap_count_o(snap_count), .snap_start_o(snap_start),
		.snap_seed_o(snap_seed), .snap_digest_o(snap_digest)
	);

	for (genvar g = 0; g < LANE_NUM; g++) begin : g_lane
		csa_lane u_lane (
			.axi_mm_clk(axi_mm_clk), .rst_n(rst_n),
			.wen_i(lane_wen[g]),
			.tag_i(job_tag), .count_i(job_count), .start_i(job_start), .seed_i(job_seed),
			.full_o(lane_full[g]), .ready_o(lane_ready[g]), .ren_i(lane_ren[g]),
			.tag_o(lane_tag[g]), .count_o(lane_count[g]), .start_o(lane_start[g]),
			.seed_o(lane_seed[g]), .digest_o(lane_digest[g])
		);
	end

endmodule

`default_nettype wire

/* hw/csa_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_lane
	import csa_pkg::*;
(
	input  logic    axi_mm_clk,
	input  logic    rst_n,
	input  logic    wen_i,
	input  word_t   tag_i,
	input  word_t   count_i,
	input  word_t   start_i,
	input  seed_t   seed_i,
	output logic    full_o,
	output logic    ready_o,
	input  logic    ren_i,
	output word_t   tag_o,
	output word_t   count_o,
	output word_t   start_o,
	output seed_t   seed_o,
	output digest_t digest_o
);

	logic full_q;
	logic busy_q;
	logic ready_q;

	word_t tag_q;
	seed_t seed_q;
	word_t count_q;
	word_t start_q;

	digest_t mix_state;
	digest_t rot_state;
	digest_t next_state;
	word_t add_q; // Start plus the iteration number
	word_t rem_q;

	assign rot_state = (mix_state << ROT_BITS) | (mix_state >> ($bits(digest_t) - ROT_BITS));
	assign next_state = (rot_state ^ digest_t'(seed_q)) + digest_t'(add_q);

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			full_q <= 1'b0;
			busy_q <= 1'b0;
			ready_q <= 1'b0;
		end else if (wen_i) begin
			full_q <= 1'b1;
			busy_q <= (count_i != '0);
			ready_q <= (count_i == '0); // Zero rounds leave the seed state as digest
		end else if (ren_i) begin
			full_q <= 1'b0;
			ready_q <= 1'b0;
		end else if (busy_q && (rem_q == word_t'(1))) begin
			busy_q <= 1'b0;
			ready_q <= 1'b1;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (wen_i) begin
			tag_q <= tag_i;
			seed_q <= seed_i;
			count_q <= count_i;
			start_q <= start_i;
			mix_state <= {tag_i, seed_i[31:0]};
			add_q <= start_i;
			rem_q <= count_i;
		end else if (busy_q) begin
			mix_state <= next_state;
			add_q <= add_q + word_t'(1);
			rem_q <= rem_q - word_t'(1);
		end
	end

	assign full_o = full_q;
	assign ready_o = ready_q;
	assign tag_o = tag_q;
	assign count_o = count_q;
	assign start_o = start_q;
	assign seed_o = seed_q;
	assign digest_o = mix_state;

endmodule

`default_nettype wire

/* hw/csa_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_dispatch
	import csa_pkg::*;
(
	input  logic       axi_mm_clk,
	input  logic       rst_n,
	input  lane_idx_t  channel_i,
	input  logic       in_ready_i,
	output logic       in_ren_o,
	input  word_t      in_rdata_i,
	input  logic       out_full_i,
	output logic       out_wen_o,
	output word_t      out_wdata_o,
	input  lane_mask_t lane_full_i,
	input  lane_mask_t lane_ready_i,
	output lane_mask_t lane_wen_o,
	output lane_mask_t lane_ren_o,
	output word_t      job_tag_o,
	output word_t      job_count_o,
	output word_t      job_start_o,
	output seed_t      job_seed_o,
	input  word_t      ret_tag_i,
	input  word_t      ret_count_i,
	input  word_t      ret_start_i,
	input  seed_t      ret_seed_i,
	input  digest_t    ret_digest_i,
	output logic       snap_in_we_o,
	output logic       snap_out_we_o,
	output word_t      snap_tag_o,
	output word_t      snap_count_o,
	output word_t      snap_start_o,
	output seed_t      snap_seed_o,
	output digest_t    snap_digest_o
);

	rd_state_e rd_state;
	logic [2:0] fetch_cnt;
	lane_idx_t fetch_ptr;
	word_t job_tag;
	seed_t job_seed;
	word_t job_count;
	word_t job_start;

	wr_state_e wr_state;
	logic [2:0] send_cnt;
	lane_idx_t coll_ptr;
	logic snap_out_pend;
	word_t rec_tag;
	seed_t rec_seed;
	word_t rec_count;
	word_t rec_start;
	digest_t rec_digest;

	function automatic lane_idx_t next_lane(input lane_idx_t idx);
		if (idx == lane_idx_t'(LANE_NUM - 1)) begin
			return '0;
		end
		return idx + lane_idx_t'(1);
	endfunction

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			rd_state <= IDLE;
			fetch_cnt <= '0;
			fetch_ptr <= '0;
		end else begin
			case (rd_state)
				IDLE: begin
					fetch_cnt <= '0;
					if (in_ready_i) begin
						rd_state <= FETCH;
					end
				end
				FETCH: begin
					fetch_cnt <= fetch_cnt + 3'd1;
					if (fetch_cnt == 3'(IN_WORDS)) begin // Last word is on the bus
						rd_state <= SEEK;
					end
				end
				SEEK: begin
					if (lane_full_i[fetch_ptr]) begin
						fetch_ptr <= next_lane(fetch_ptr);
					end else begin
						rd_state <= LOAD;
					end
				end
				LOAD: begin
					fetch_ptr <= next_lane(fetch_ptr); // Next search starts one lane on
					rd_state <= IDLE;
				end
				default: rd_state <= IDLE;
			endcase
		end
	end

	// Word k arrives one cycle after its read pulse, when fetch_cnt is k + 1
	always_ff @(posedge axi_mm_clk) begin
		if (rd_state == FETCH) begin
			case (fetch_cnt)
				3'd1: job_tag <= in_rdata_i;
				3'd2: job_seed[31:0] <= in_rdata_i;
				3'd3: job_seed[47:32] <= in_rdata_i[15:0];
				3'd4: job_count <= in_rdata_i;
				3'd5: job_start <= in_rdata_i;
				default: ;
			endcase
		end
	end

	assign in_ren_o = (rd_state == FETCH) && (fetch_cnt < 3'(IN_WORDS));
	assign lane_wen_o = (rd_state == LOAD) ? (lane_mask_t'(1) << fetch_ptr) : '0;
	assign snap_in_we_o = (rd_state == LOAD) && (fetch_ptr == channel_i);

	assign job_tag_o = job_tag;
	assign job_seed_o = job_seed;
	assign job_count_o = job_count;
	assign job_start_o = job_start;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			wr_state <= SCAN;
			send_cnt <= '0;
			coll_ptr <= '0;
			snap_out_pend <= 1'b0;
		end else begin
			if (snap_out_we_o) begin
				snap_out_pend <= 1'b0;
			end
			case (wr_state)
				SCAN: begin
					if (!lane_ready_i[coll_ptr]) begin
						coll_ptr <= next_lane(coll_ptr);
					end else if (!out_full_i) begin
						wr_state <= TAKE; // A full FIFO leaves the result in its lane
					end
				end
				TAKE: wr_state <= HOLD;
				HOLD: begin
					send_cnt <= '0;
					wr_state <= SEND;
					if (coll_ptr == channel_i) begin
						snap_out_pend <= 1'b1;
					end
				end
				SEND: begin
					if (out_wen_o) begin
						if (send_cnt == 3'(OUT_WORDS - 1)) begin
							coll_ptr <= next_lane(coll_ptr);
							wr_state <= SCAN;
						end else begin
							send_cnt <= send_cnt + 3'd1;
						end
					end
				end
				default: wr_state <= SCAN;
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (wr_state == HOLD) begin
			rec_tag <= ret_tag_i;
			rec_seed <= ret_seed_i;
			rec_count <= ret_count_i;
			rec_start <= ret_start_i;
			rec_digest <= ret_digest_i;
		end
	end

	assign lane_ren_o = (wr_state == TAKE) ? (lane_mask_t'(1) << coll_ptr) : '0;
	assign out_wen_o = (wr_state == SEND) && ((send_cnt != '0) || !out_full_i);

	always_comb begin
		case (send_cnt)
			3'd0: out_wdata_o = rec_tag;
			3'd1: out_wdata_o = rec_seed[31:0];
			3'd2: out_wdata_o = word_t'(rec_seed[47:32]);
			3'd3: out_wdata_o = rec_count;
			3'd4: out_wdata_o = rec_start;
			3'd5: out_wdata_o = rec_digest[31:0];
			3'd6: out_wdata_o = rec_digest[63:32];
			default: out_wdata_o = '0;
		endcase
	end

	// A job load takes the shared snapshot bus first and a result waits one cycle
	assign snap_out_we_o = snap_out_pend && !snap_in_we_o;
	assign snap_tag_o = snap_in_we_o ? job_tag : rec_tag;
	assign snap_seed_o = snap_in_we_o ? job_seed : rec_seed;
	assign snap_count_o = snap_in_we_o ? job_count : rec_count;
	assign snap_start_o = snap_in_we_o ? job_start : rec_start;
	assign snap_digest_o = rec_digest;

endmodule

`default_nettype wire

/* hw/csa_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_regs
	import csa_pkg::*, csa_regmap_pkg::*;
(
	input  logic      axi_mm_clk,
	input  logic      rst_n,
	input  logic      wen_i,
	input  addr_t     waddr_i,
	input  word_t     wdata_i,
	input  logic      ren_i,
	input  addr_t     raddr_i,
	output word_t     rdata_o,
	output lane_idx_t channel_o,
	input  logic      snap_in_we_i,
	input  logic      snap_out_we_i,
	input  word_t     snap_tag_i,
	input  word_t     snap_count_i,
	input  word_t     snap_start_i,
	input  seed_t     snap_seed_i,
	input  digest_t   snap_digest_i
);

	lane_idx_t channel;
	logic chan_changed;
	logic in_valid;
	logic out_valid;

	word_t in_tag;
	seed_t in_seed;
	word_t in_count;
	word_t in_start;

	word_t out_tag;
	seed_t out_seed;
	word_t out_count;
	word_t out_start;
	digest_t out_digest;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			channel <= '0;
			chan_changed <= 1'b0;
		end else begin
			chan_changed <= 1'b0;
			if (wen_i && (waddr_i == ADDR_CHANNEL) && (wdata_i < word_t'(LANE_NUM))) begin
				channel <= lane_idx_t'(wdata_i);
				chan_changed <= 1'b1; // Old snapshots belong to another lane now
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			in_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (chan_changed) begin
				in_valid <= 1'b0;
				out_valid <= 1'b0;
			end else begin
				if (snap_in_we_i) begin
					in_valid <= 1'b1;
				end
				if (snap_out_we_i) begin
					out_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (snap_in_we_i) begin
			in_tag <= snap_tag_i;
			in_seed <= snap_seed_i;
			in_count <= snap_count_i;
			in_start <= snap_start_i;
		end
		if (snap_out_we_i) begin
			out_tag <= snap_tag_i;
			out_seed <= snap_seed_i;
			out_count <= snap_count_i;
			out_start <= snap_start_i;
			out_digest <= snap_digest_i;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			rdata_o <= '0;
		end else if (ren_i) begin
			case (raddr_i)
				ADDR_CHANNEL:   rdata_o <= word_t'(channel);
				ADDR_IN_VALID:  rdata_o <= word_t'(in_valid);
				ADDR_IN_0:      rdata_o <= in_tag;
				ADDR_IN_1:      rdata_o <= in_seed[31:0];
				ADDR_IN_2:      rdata_o <= word_t'(in_seed[47:32]);
				ADDR_IN_3:      rdata_o <= in_count;
				ADDR_IN_4:      rdata_o <= in_start;
				ADDR_OUT_VALID: rdata_o <= word_t'(out_valid);
				ADDR_OUT_0:     rdata_o <= out_tag;
				ADDR_OUT_1:     rdata_o <= out_seed[31:0];
				ADDR_OUT_2:     rdata_o <= word_t'(out_seed[47:32]);
				ADDR_OUT_3:     rdata_o <= out_count;
				ADDR_OUT_4:     rdata_o <= out_start;
				ADDR_OUT_5:     rdata_o <= out_digest[31:0];
				ADDR_OUT_6:     rdata_o <= out_digest[63:32];
				default:        rdata_o <= {UNMAPPED_TAG, {(16 - ADDR_BITS){1'b0}}, raddr_i};
			endcase
		end
	end

	assign channel_o = channel;

endmodule

`default_nettype wire

/* hw/csa_regmap_pkg.sv */
`default_nettype none

package csa_regmap_pkg;

	localparam int ADDR_BITS = 10;

	typedef logic [ADDR_BITS-1:0] addr_t;

	localparam addr_t ADDR_CHANNEL = addr_t'(0);

	localparam addr_t ADDR_IN_VALID = addr_t'(1);
	localparam addr_t ADDR_IN_0 = addr_t'(2);
	localparam addr_t ADDR_IN_1 = addr_t'(3);
	localparam addr_t ADDR_IN_2 = addr_t'(4);
	localparam addr_t ADDR_IN_3 = addr_t'(5);
	localparam addr_t ADDR_IN_4 = addr_t'(6);

	localparam addr_t ADDR_OUT_VALID = addr_t'(7);
	localparam addr_t ADDR_OUT_0 = addr_t'(8);
	localparam addr_t ADDR_OUT_1 = addr_t'(9);
	localparam addr_t ADDR_OUT_2 = addr_t'(10);
	localparam addr_t ADDR_OUT_3 = addr_t'(11);
	localparam addr_t ADDR_OUT_4 = addr_t'(12);
	localparam addr_t ADDR_OUT_5 = addr_t'(13);
	localparam addr_t ADDR_OUT_6 = addr_t'(14);

	localparam logic [15:0] UNMAPPED_TAG = 16'hE000; // Upper half of a read from a hole

endpackage

`default_nettype wire

/* hw/csa_pkg.sv */
`default_nettype none

package csa_pkg;

	localparam int LANE_NUM = 4;
	localparam int IN_WORDS = 5; // Tag, seed low, seed high, count, start
	localparam int OUT_WORDS = 7; // Input record followed by the two digest words
	localparam int ROT_BITS = 7;

	typedef logic [31:0] word_t;
	typedef logic [47:0] seed_t;
	typedef logic [63:0] digest_t;

	typedef logic [$clog2(LANE_NUM)-1:0] lane_idx_t;
	typedef logic [LANE_NUM-1:0] lane_mask_t;

	// Job fetch from the input FIFO and hand-off to a free lane
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		SEEK,
		LOAD
	} rd_state_e;

	// Result collection from the lanes and streaming to the output FIFO
	typedef enum logic [1:0] {
		SCAN,
		TAKE,
		HOLD,
		SEND
	} wr_state_e;

endpackage

`default_nettype wire
